//--- list.f
design/conv_pkg.sv
design/conv_in_fifo.sv
design/conv_row_pe.sv
design/psum_fifo.sv
design/conv_out_port.sv
design/conv2d_top.sv
tests/tb_clock_gen.sv
tests/conv2d_tb.sv

//--- Makefile
# Verilator build and run of the convolution engine testbench
VERILATOR ?= verilator
TOP       ?= conv2d_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/conv2d_tb.sv
// testbench for the 2D convolution engine with random frames checked against a reference model
`default_nettype none

module conv2d_tb;

    localparam int SEED    = 32'h03c8_e941;
    localparam int NFRAMES = 5;
    localparam int KSIZE   = conv_pkg::WT_DIM * conv_pkg::WT_DIM;

    wire                   clk;
    logic                  reset;
    conv_pkg::dim_t        fm_dim;
    conv_pkg::data_t       weight;
    logic                  weight_valid;
    conv_pkg::data_t       fm_word      = '0;
    logic                  fm_valid     = 1'b0;
    logic                  out_credit   = 1'b0;
    wire                   in_credit;
    wire conv_pkg::acc_t   out_word;
    wire                   out_valid;

    int    seed;
    int    frame_dims [NFRAMES] = '{4, 16, 5, 7, 6};
    int    cycles        = 0;
    int    timeout_limit = 2000;
    int    src_credits   = conv_pkg::IN_DEPTH;
    int    sink_credits  = 0;
    int    granted       = 0;
    int    grant_limit   = 0;
    int    got_total     = 0;
    int    gap_pct       = 0;
    int    grant_pct     = 0;
    bit    stream_on     = 1'b0;
    string test_name     = "reset";

    conv_pkg::data_t kern  [KSIZE];
    conv_pkg::data_t frame [conv_pkg::FM_MAX * conv_pkg::FM_MAX];
    conv_pkg::data_t src_q [$];
    conv_pkg::acc_t  exp_q [$];

    tb_clock_gen #(
        .PERIOD (40)
    ) u_clk (
        .clk_o (clk)
    );

    conv2d_top u_dut (
        .clk            (clk),
        .reset_i        (reset),
        .fm_dim_i       (fm_dim),
        .weight_i       (weight),
        .weight_valid_i (weight_valid),
        .fm_i           (fm_word),
        .fm_valid_i     (fm_valid),
        .in_credit_o    (in_credit),
        .out_credit_i   (out_credit),
        .out_o          (out_word),
        .out_valid_o    (out_valid)
    );

    function automatic conv_pkg::data_t rand_word();
        return conv_pkg::data_t'($random(seed));
    endfunction

    function automatic int pick_below(input int n);
        int unsigned r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // kernel row i lands on map row r+i-1 and the halo reads as zero
    function automatic conv_pkg::acc_t model_pixel(input int dim, input int r, input int c);
        conv_pkg::acc_t acc;
        int             y;
        int             x;
        acc = '0;
        for (int i = 0; i < conv_pkg::WT_DIM; i++) begin
            for (int j = 0; j < conv_pkg::WT_DIM; j++) begin
                y = r + i - 1;
                x = c + j - 1;
                if (y >= 0 && y < dim && x >= 0 && x < dim) begin
                    acc = acc + conv_pkg::acc_t'(kern[i * conv_pkg::WT_DIM + j])
                              * conv_pkg::acc_t'(frame[y * dim + x]);
                end
            end
        end
        return acc;
    endfunction

    task automatic expect_true(input bit ok, input string what);
        assert (ok) else begin
            $display("%s (test %s)", what, test_name);
            $display("TEST FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic compare_result(input conv_pkg::acc_t expected, input conv_pkg::acc_t actual);
        assert (actual === expected) else begin
            $display("FAILED %s result %0d: expected %h, actual %h",
                     test_name, got_total, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    // loads a kernel, streams one map and waits for all of its results
    task automatic run_frame(input string name, input int dim, input bit centre_only,
                             input int gaps, input int grants);
        int target;
        @(posedge clk);
        test_name = name;
        for (int k = 0; k < KSIZE; k++) begin
            kern[k] = centre_only ? conv_pkg::data_t'(k == KSIZE / 2) : rand_word();
        end
        for (int p = 0; p < dim * dim; p++) begin
            frame[p] = rand_word();
        end
        for (int r = 0; r < dim; r++) begin
            for (int c = 0; c < dim; c++) begin
                if (centre_only) begin
                    exp_q.push_back(conv_pkg::acc_t'(frame[r * dim + c]));
                end else begin
                    exp_q.push_back(model_pixel(dim, r, c));
                end
            end
        end
        target = got_total + dim * dim;

        @(negedge clk);
        fm_dim = conv_pkg::dim_t'(dim);
        for (int k = 0; k < KSIZE; k++) begin
            @(negedge clk);
            weight       = kern[k];
            weight_valid = 1'b1;
        end
        @(negedge clk);
        weight_valid = 1'b0;

        @(posedge clk);
        gap_pct     = gaps;
        grant_pct   = grants;
        grant_limit = target;
        for (int p = 0; p < dim * dim; p++) begin
            src_q.push_back(frame[p]);
        end
        while (got_total < target) begin
            @(posedge clk);
        end
        expect_true(src_credits == conv_pkg::IN_DEPTH, "input credits missing after the frame");
    endtask

    // source, sink and result monitor on the falling edge
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_limit) begin
            $display("timeout after %0d cycles in %s, %0d of %0d results received",
                     cycles, test_name, got_total, grant_limit);
            $display("TEST FAIL");
            $fatal(1, "cycle limit reached");
        end else if (stream_on) begin
            if (in_credit) begin
                src_credits = src_credits + 1;
                expect_true(src_credits <= conv_pkg::IN_DEPTH,
                            "more input credits came back than words were outstanding");
            end
            if (out_valid) begin
                expect_true(sink_credits > 0, "a result arrived while the sink held no credit");
                expect_true(exp_q.size() != 0, "a result arrived that no frame accounts for");
                compare_result(exp_q.pop_front(), out_word);
                sink_credits = sink_credits - 1;
                got_total    = got_total + 1;
            end
            if (src_q.size() != 0 && src_credits > 0 && pick_below(100) >= gap_pct) begin
                fm_valid    = 1'b1;
                fm_word     = src_q.pop_front();
                src_credits = src_credits - 1;
            end else begin
                fm_valid = 1'b0;
                fm_word  = rand_word();
            end
            if (granted < grant_limit && pick_below(100) < grant_pct) begin
                out_credit   = 1'b1;
                granted      = granted + 1;
                sink_credits = sink_credits + 1;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        seed = SEED;
        for (int f = 0; f < NFRAMES; f++) begin
            timeout_limit = timeout_limit + 40 * frame_dims[f] * frame_dims[f];
        end
        reset        = 1'b1;
        fm_dim       = '0;
        weight       = '0;
        weight_valid = 1'b0;
        repeat (16) @(negedge clk);
        expect_true(!in_credit && !out_valid, "output strobes active during reset");
        reset = 1'b0;
        @(posedge clk);
        stream_on = 1'b1;

        run_frame("basic_4x4", frame_dims[0], 1'b0, 0, 100);
        run_frame("full_map_with_gaps", frame_dims[1], 1'b0, 35, 80);
        run_frame("rare_credit", frame_dims[2], 1'b0, 10, 8);
        run_frame("reload_new_size", frame_dims[3], 1'b0, 20, 60);
        run_frame("centre_identity", frame_dims[4], 1'b1, 25, 50);

        // spare credits let any stray result out where the monitor sees it
        test_name   = "no_stray_results";
        grant_pct   = 100;
        grant_limit = granted + conv_pkg::OUT_DEPTH;
        repeat (50) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// testbench clock source, free running square wave
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- design/conv2d_top.sv
// 2D convolution engine: input FIFO, row elements, partial-sum FIFOs and output port
`default_nettype none

module conv2d_top (
    input  wire                  clk,
    input  wire                  reset_i,

    // map side, stable for the whole frame
    input  wire conv_pkg::dim_t  fm_dim_i,

    // kernel weights in raster order
    input  wire conv_pkg::data_t weight_i,
    input  wire                  weight_valid_i,

    // feature map input channel
    input  wire conv_pkg::data_t fm_i,
    input  wire                  fm_valid_i,
    output wire                  in_credit_o,

    // result channel
    input  wire                  out_credit_i,
    output wire conv_pkg::acc_t  out_o,
    output wire                  out_valid_o
);

    wire conv_pkg::data_t                      fifo_word;
    wire                                       fifo_ready;
    wire [conv_pkg::WT_DIM-1:0]                pe_pop;
    wire conv_pkg::acc_t                       pe_psum [conv_pkg::WT_DIM];
    wire [conv_pkg::WT_DIM-1:0]                pe_psum_valid;
    wire conv_pkg::acc_t [conv_pkg::WT_DIM-1:0] psum_rd;
    wire [conv_pkg::WT_DIM-1:0]                psum_ne;
    wire                                       psum_pop;
    wire                                       hold;

    // every element pops in lockstep, element 0 speaks for all of them
    conv_in_fifo u_in_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .fm_i        (fm_i),
        .fm_valid_i  (fm_valid_i),
        .pop_i       (pe_pop[0]),
        .word_o      (fifo_word),
        .ready_o     (fifo_ready),
        .in_credit_o (in_credit_o)
    );

    for (genvar g = 0; g < conv_pkg::WT_DIM; g++) begin : g_row
        conv_row_pe #(
            .ROW (g)
        ) u_pe (
            .clk            (clk),
            .reset_i        (reset_i),
            .fm_dim_i       (fm_dim_i),
            .weight_i       (weight_i),
            .weight_valid_i (weight_valid_i),
            .word_i         (fifo_word),
            .ready_i        (fifo_ready),
            .hold_i         (hold),
            .pop_o          (pe_pop[g]),
            .psum_o         (pe_psum[g]),
            .psum_valid_o   (pe_psum_valid[g])
        );

        psum_fifo u_psum (
            .clk         (clk),
            .reset_i     (reset_i),
            .wr_data_i   (pe_psum[g]),
            .wr_en_i     (pe_psum_valid[g]),
            .rd_en_i     (psum_pop),
            .rd_data_o   (psum_rd[g]),
            .not_empty_o (psum_ne[g])
        );
    end

    conv_out_port u_out (
        .clk          (clk),
        .reset_i      (reset_i),
        .psum_i       (psum_rd),
        .psum_ready_i (psum_ne),
        .out_credit_i (out_credit_i),
        .psum_pop_o   (psum_pop),
        .hold_o       (hold),
        .out_o        (out_o),
        .out_valid_o  (out_valid_o)
    );

endmodule

`default_nettype wire

//--- design/conv_out_port.sv
// output port: sums aligned row partials, queues results and releases one per credit
`default_nettype none

module conv_out_port (
    input  wire                                          clk,
    input  wire                                          reset_i,
    input  wire conv_pkg::acc_t [conv_pkg::WT_DIM-1:0]   psum_i,
    input  wire [conv_pkg::WT_DIM-1:0]                   psum_ready_i,
    input  wire                                          out_credit_i,
    output logic                                         psum_pop_o,
    output logic                                         hold_o,
    output conv_pkg::acc_t                               out_o,
    output logic                                         out_valid_o
);

    conv_pkg::acc_t mem [conv_pkg::OUT_DEPTH];
    conv_pkg::acc_t sum;

    logic [$clog2(conv_pkg::OUT_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(conv_pkg::OUT_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(conv_pkg::OUT_DEPTH+1)-1:0] count;
    logic [conv_pkg::CRED_W-1:0]              credits;
    logic                                     push;
    logic                                     send;

    // all rows must have their partial for the same output position
    assign push       = (&psum_ready_i) && (int'(count) != conv_pkg::OUT_DEPTH);
    assign psum_pop_o = push;
    assign send       = (credits != '0) && (count != '0);

    // leave room for partials still in flight behind a stopped scan
    assign hold_o = (int'(count) >= conv_pkg::OUT_DEPTH - 2);

    always_comb begin
        sum = '0;
        for (int r = 0; r < conv_pkg::WT_DIM; r++) begin
            sum = sum + psum_i[r];
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= sum;
        end
        if (send) begin
            out_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credits     <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= send;
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == conv_pkg::OUT_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (int'(rd_ptr) == conv_pkg::OUT_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({out_credit_i, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/psum_fifo.sv
// partial-sum FIFO, buffers one row element's results while the later rows catch up
`default_nettype none

module psum_fifo (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire conv_pkg::acc_t wr_data_i,
    input  wire                 wr_en_i,
    input  wire                 rd_en_i,
    output conv_pkg::acc_t      rd_data_o,
    output logic                not_empty_o
);

    conv_pkg::acc_t mem [conv_pkg::PSUM_DEPTH];

    logic [$clog2(conv_pkg::PSUM_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(conv_pkg::PSUM_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(conv_pkg::PSUM_DEPTH+1)-1:0] count;
    logic                                      push;
    logic                                      pop;

    assign push        = wr_en_i && (int'(count) != conv_pkg::PSUM_DEPTH);
    assign pop         = rd_en_i && not_empty_o;
    assign not_empty_o = (count != '0);
    assign rd_data_o   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == conv_pkg::PSUM_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == conv_pkg::PSUM_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/conv_row_pe.sv
// row processing element that walks the haloed map and emits one dot product per window
`default_nettype none

module conv_row_pe #(
    parameter int ROW = 0
) (
    input  wire                  clk,
    input  wire                  reset_i,
    input  wire conv_pkg::dim_t  fm_dim_i,
    input  wire conv_pkg::data_t weight_i,
    input  wire                  weight_valid_i,
    input  wire conv_pkg::data_t word_i,
    input  wire                  ready_i,
    input  wire                  hold_i,
    output logic                 pop_o,
    output conv_pkg::acc_t       psum_o,
    output logic                 psum_valid_o
);

    conv_pkg::pe_state_t state;

    // m counts kernel rows and n counts columns during weight load
    conv_pkg::dim_t m_cnt;
    conv_pkg::dim_t n_cnt;
    conv_pkg::dim_t wt_last;

    // padded scan position
    conv_pkg::dim_t x_cnt;
    conv_pkg::dim_t y_cnt;
    conv_pkg::dim_t edge_pos;
    conv_pkg::dim_t y_first;
    conv_pkg::dim_t y_stop;

    // older window words, the current word joins them in win_nxt
    conv_pkg::data_t kernel  [conv_pkg::WT_DIM];
    conv_pkg::data_t win     [conv_pkg::WT_DIM-1];
    conv_pkg::data_t win_nxt [conv_pkg::WT_DIM];
    conv_pkg::acc_t  dot;

    logic load_last;
    logic halo;
    logic step;
    logic emit;
    logic row_end;
    logic frame_end;

    assign wt_last  = conv_pkg::dim_t'(conv_pkg::WT_DIM - 1);
    assign edge_pos = fm_dim_i + conv_pkg::dim_t'(1);
    assign y_first  = conv_pkg::dim_t'(ROW);
    assign y_stop   = fm_dim_i + conv_pkg::dim_t'(ROW);

    assign load_last = (state == conv_pkg::PE_LOAD) && weight_valid_i
                       && (m_cnt == wt_last) && (n_cnt == wt_last);

    assign halo = (x_cnt == '0) || (y_cnt == '0) || (x_cnt == edge_pos) || (y_cnt == edge_pos);

    // halo steps need no input word
    assign step  = (state == conv_pkg::PE_SCAN) && !hold_i && (halo || ready_i);
    assign pop_o = step && !halo;

    assign row_end   = (x_cnt == edge_pos);
    assign frame_end = step && row_end && (y_cnt == edge_pos);

    // rows ROW .. ROW+fm_dim-1 of the padded grid feed this kernel row
    assign emit = step && (x_cnt >= wt_last) && (y_cnt >= y_first) && (y_cnt < y_stop);

    // window after this step with the newest word in entry 0
    always_comb begin
        win_nxt[0] = halo ? '0 : word_i;
        for (int i = 1; i < conv_pkg::WT_DIM; i++) begin
            win_nxt[i] = win[i-1];
        end
    end

    // oldest word meets kernel column 0
    always_comb begin
        dot = '0;
        for (int c = 0; c < conv_pkg::WT_DIM; c++) begin
            dot = dot + conv_pkg::acc_t'(win_nxt[conv_pkg::WT_DIM-1-c])
                      * conv_pkg::acc_t'(kernel[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= conv_pkg::PE_LOAD;
            m_cnt        <= '0;
            n_cnt        <= '0;
            x_cnt        <= '0;
            y_cnt        <= '0;
            psum_valid_o <= 1'b0;
            for (int c = 0; c < conv_pkg::WT_DIM; c++) begin
                kernel[c] <= '0;
            end
        end else begin
            psum_valid_o <= emit;

            if (state == conv_pkg::PE_LOAD && weight_valid_i) begin
                for (int c = 0; c < conv_pkg::WT_DIM; c++) begin
                    if (m_cnt == y_first && n_cnt == conv_pkg::dim_t'(c)) begin
                        kernel[c] <= weight_i;
                    end
                end
                if (n_cnt == wt_last) begin
                    n_cnt <= '0;
                    m_cnt <= (m_cnt == wt_last) ? '0 : m_cnt + conv_pkg::dim_t'(1);
                end else begin
                    n_cnt <= n_cnt + conv_pkg::dim_t'(1);
                end
            end

            if (load_last) begin
                state <= conv_pkg::PE_SCAN;
            end

            if (step) begin
                if (row_end) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == edge_pos) ? '0 : y_cnt + conv_pkg::dim_t'(1);
                end else begin
                    x_cnt <= x_cnt + conv_pkg::dim_t'(1);
                end
            end

            // a frame uses its kernel once
            if (frame_end) begin
                state <= conv_pkg::PE_LOAD;
                for (int c = 0; c < conv_pkg::WT_DIM; c++) begin
                    kernel[c] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            for (int i = 0; i < conv_pkg::WT_DIM - 1; i++) begin
                win[i] <= win_nxt[i];
            end
        end
        if (emit) begin
            psum_o <= dot;
        end
    end

endmodule

`default_nettype wire

//--- design/conv_in_fifo.sv
// input word FIFO, hands one credit back upstream for each word it pops
`default_nettype none

module conv_in_fifo (
    input  wire                  clk,
    input  wire                  reset_i,
    input  wire conv_pkg::data_t fm_i,
    input  wire                  fm_valid_i,
    input  wire                  pop_i,
    output conv_pkg::data_t      word_o,
    output logic                 ready_o,
    output logic                 in_credit_o
);

    conv_pkg::data_t mem [conv_pkg::IN_DEPTH];

    logic [$clog2(conv_pkg::IN_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(conv_pkg::IN_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(conv_pkg::IN_DEPTH+1)-1:0] count;
    logic                                    push;
    logic                                    pop;

    // the credit scheme keeps the source from writing into a full buffer
    assign push    = fm_valid_i;
    assign pop     = pop_i && ready_o;
    assign ready_o = (count != '0);
    assign word_o  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fm_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            in_credit_o <= 1'b0;
        end else begin
            in_credit_o <= pop;
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == conv_pkg::IN_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == conv_pkg::IN_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/conv_pkg.sv
// conv package: shared widths, sizes, word types and the row element state encoding
`default_nettype none

package conv_pkg;

    // word widths
    localparam int DWIDTH = 16;
    localparam int AWIDTH = 32;

    // kernel side, also the number of row elements
    localparam int WT_DIM = 3;

    // largest map side and the counter width that covers FM_MAX + 1
    localparam int FM_MAX = 16;
    localparam int DIM_W  = 6;

    // FIFO sizes
    localparam int IN_DEPTH   = 4;
    localparam int OUT_DEPTH  = 8;
    localparam int PSUM_DEPTH = (WT_DIM - 1) * FM_MAX + 4;

    // output credit counter width
    localparam int CRED_W = 16;

    typedef logic [DWIDTH-1:0] data_t;
    typedef logic [AWIDTH-1:0] acc_t;
    typedef logic [DIM_W-1:0]  dim_t;

    typedef enum logic {
        PE_LOAD,
        PE_SCAN
    } pe_state_t;

endpackage

`default_nettype wire
